// File: bench/tb_cpu_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_frontend
	import cpu_config_pkg::*, cpu_types_pkg::*;
();

	localparam int MEM_WORDS = 512;

	logic i_clock;
	logic i_rst;
	logic o_ibus_request;
	logic [XLEN-1:0] o_ibus_address;
	logic i_ibus_ready;
	logic [ILEN-1:0] i_ibus_rdata;
	logic i_busy;
	logic i_jump;
	logic [XLEN-1:0] i_jump_pc;
	logic o_valid;
	logic [XLEN-1:0] o_pc;
	op_class_t o_op;
	logic [2:0] o_funct3;
	logic [6:0] o_funct7;
	logic [4:0] o_rd;
	logic [4:0] o_rs1;
	logic [4:0] o_rs2;
	logic [XLEN-1:0] o_imm;
	logic o_illegal;

	logic [ILEN-1:0] mem [0:MEM_WORDS-1];
	int done_cycle [0:MEM_WORDS-1];
	logic [XLEN-1:0] done_addr [$];
	int max_delay = 0;
	int cycle = 0;
	int errors = 0;

	cpu_frontend cpu_frontend_inst (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.o_ibus_request(o_ibus_request),
		.o_ibus_address(o_ibus_address),
		.i_ibus_ready(i_ibus_ready),
		.i_ibus_rdata(i_ibus_rdata),
		.i_busy(i_busy),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.o_valid(o_valid),
		.o_pc(o_pc),
		.o_op(o_op),
		.o_funct3(o_funct3),
		.o_funct7(o_funct7),
		.o_rd(o_rd),
		.o_rs1(o_rs1),
		.o_rs2(o_rs2),
		.o_imm(o_imm),
		.o_illegal(o_illegal)
	);

	initial begin
		i_clock = 1'b0;
		forever #2 i_clock = ~i_clock;
	end

	always @(posedge i_clock) cycle <= cycle + 1;

	//============================================================
	// Instruction encoders and memory helpers
	//============================================================

	function automatic int word_index(input logic [XLEN-1:0] addr);
		return int'(addr[10:2]);
	endfunction

	function automatic logic [31:0] enc_i(input int imm, input int rs1, input logic [2:0] f3,
			input int rd, input logic [6:0] opc);
		logic [11:0] im;
		im = 12'(imm);
		return {im, 5'(rs1), f3, 5'(rd), opc};
	endfunction

	function automatic logic [31:0] enc_s(input int imm, input int rs1, input int rs2,
			input logic [2:0] f3);
		logic [11:0] im;
		im = 12'(imm);
		return {im[11:5], 5'(rs2), 5'(rs1), f3, im[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input int imm, input int rs1, input int rs2,
			input logic [2:0] f3);
		logic [12:0] im;
		im = 13'(imm);
		return {im[12], im[10:5], 5'(rs2), 5'(rs1), f3, im[4:1], im[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] opc);
		return {20'(imm), 5'(rd), opc};
	endfunction

	function automatic logic [31:0] enc_j(input int imm, input int rd);
		logic [20:0] im;
		im = 21'(imm);
		return {im[20], im[10:1], im[11], im[19:12], 5'(rd), OPC_JAL};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs1, input int rs2,
			input logic [2:0] f3, input int rd);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
	endfunction

	task automatic put(input logic [XLEN-1:0] addr, input logic [31:0] word);
		mem[word_index(addr)] = word;
	endtask

	task automatic init_memory();
		int i;
		// ADDI words whose fields all follow the word index
		for (i = 0; i < MEM_WORDS; i++) begin
			mem[i] = {3'b000, 9'(i), 5'(i), 3'b000, 5'(i >> 4), OPC_OP_IMM};
		end
		// One word of every format at 0x100
		put(32'h100, enc_u('hABCDE, 5, OPC_LUI));
		put(32'h104, enc_u('h80001, 6, OPC_AUIPC));
		put(32'h108, enc_j(-8, 1));
		put(32'h10c, enc_i(-4, 3, 3'b000, 2, OPC_JALR));
		put(32'h110, enc_b(-16, 4, 5, 3'b001));
		put(32'h114, enc_i(-2048, 8, 3'b010, 7, OPC_LOAD));
		put(32'h118, enc_s(-100, 10, 9, 3'b010));
		put(32'h11c, enc_i(-1, 12, 3'b000, 11, OPC_OP_IMM));
		put(32'h120, enc_r(7'h20, 14, 15, 3'b000, 13));
		put(32'h124, enc_i('h305, 17, 3'b001, 16, OPC_SYSTEM));
		// Illegal words mixed with two legal ones at 0x200
		put(32'h200, 32'h00000000);
		put(32'h204, enc_i(5, 1, 3'b000, 2, OPC_OP_IMM));
		put(32'h208, 32'hffffffff);
		put(32'h20c, {25'h1234, 7'b0001011});
		put(32'h210, 32'h00158591);
		put(32'h214, enc_r(7'h00, 2, 3, 3'b000, 1));
		// Random words at 0x300
		for (i = 0; i < 40; i++) begin
			put(32'h300 + 32'(4 * i), $urandom);
		end
	endtask

	//============================================================
	// Reference decoder
	//============================================================

	function automatic decode_data_t ref_decode(input logic [XLEN-1:0] pc, input logic [31:0] w);
		decode_data_t d;
		logic [12:0] b_off;
		logic [20:0] j_off;
		b_off = {w[31], w[7], w[30:25], w[11:8], 1'b0};
		j_off = {w[31], w[19:12], w[20], w[30:21], 1'b0};
		d.pc = pc;
		d.funct3 = w[14:12];
		d.funct7 = w[31:25];
		d.rd = w[11:7];
		d.rs1 = w[19:15];
		d.rs2 = w[24:20];
		d.op = OP_ILLEGAL;
		d.imm = '0;
		if (w[1:0] == 2'b11) begin
			case (w[6:0])
				OPC_LUI:    d.op = OP_LUI;
				OPC_AUIPC:  d.op = OP_AUIPC;
				OPC_JAL:    d.op = OP_JAL;
				OPC_JALR:   d.op = OP_JALR;
				OPC_BRANCH: d.op = OP_BRANCH;
				OPC_LOAD:   d.op = OP_LOAD;
				OPC_STORE:  d.op = OP_STORE;
				OPC_OP_IMM: d.op = OP_ALU_IMM;
				OPC_OP:     d.op = OP_ALU;
				OPC_SYSTEM: d.op = OP_SYSTEM;
				default:    d.op = OP_ILLEGAL;
			endcase
			case (w[6:0])
				OPC_LUI, OPC_AUIPC: d.imm = {w[31:12], 12'h000};
				OPC_JAL:            d.imm = 32'($signed(j_off));
				OPC_BRANCH:         d.imm = 32'($signed(b_off));
				OPC_STORE:          d.imm = 32'($signed({w[31:25], w[11:7]}));
				OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_SYSTEM: d.imm = 32'($signed(w[31:20]));
				default:            d.imm = '0;
			endcase
		end
		d.illegal = (d.op == OP_ILLEGAL);
		return d;
	endfunction

	function automatic decode_data_t read_output();
		decode_data_t d;
		d.pc = o_pc;
		d.op = o_op;
		d.funct3 = o_funct3;
		d.funct7 = o_funct7;
		d.rd = o_rd;
		d.rs1 = o_rs1;
		d.rs2 = o_rs2;
		d.imm = o_imm;
		d.illegal = o_illegal;
		return d;
	endfunction

	//============================================================
	// Instruction memory model
	//============================================================

	function automatic int pick_delay();
		if (max_delay == 0) begin
			return 0;
		end
		return int'($urandom % 32'(max_delay + 1));
	endfunction

	initial begin : ibus_model
		logic prev_req;
		logic prev_ready;
		logic [XLEN-1:0] prev_addr;
		int wait_left;
		i_ibus_ready = 1'b0;
		i_ibus_rdata = '0;
		prev_req = 1'b0;
		prev_ready = 1'b0;
		prev_addr = '0;
		wait_left = 0;
		forever begin
			@(posedge i_clock);
			#1;
			i_ibus_ready = 1'b0;
			i_ibus_rdata = '0;
			if (!i_rst && o_ibus_request) begin
				// New request after a completion, a gap or a redirect
				if (!prev_req || prev_ready || o_ibus_address != prev_addr) begin
					wait_left = pick_delay();
				end
				if (wait_left == 0) begin
					i_ibus_ready = 1'b1;
					i_ibus_rdata = mem[word_index(o_ibus_address)];
					done_cycle[word_index(o_ibus_address)] = cycle;
					done_addr.push_back(o_ibus_address);
				end else begin
					wait_left--;
				end
			end
			prev_req = !i_rst && o_ibus_request;
			prev_ready = i_ibus_ready;
			prev_addr = o_ibus_address;
		end
	end

	//============================================================
	// Checks and stimulus tasks
	//============================================================

	task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", what, expected, actual);
		end
	endtask

	task automatic check_item(input string name, input decode_data_t exp, input decode_data_t act);
		check({name, " pc"}, exp.pc, act.pc);
		check({name, " op"}, 32'(exp.op), 32'(act.op));
		check({name, " funct3"}, 32'(exp.funct3), 32'(act.funct3));
		check({name, " funct7"}, 32'(exp.funct7), 32'(act.funct7));
		check({name, " rd"}, 32'(exp.rd), 32'(act.rd));
		check({name, " rs1"}, 32'(exp.rs1), 32'(act.rs1));
		check({name, " rs2"}, 32'(exp.rs2), 32'(act.rs2));
		check({name, " imm"}, exp.imm, act.imm);
		check({name, " illegal"}, 32'(exp.illegal), 32'(act.illegal));
	endtask

	// Accepts count outputs, which must follow start in steps of 4
	task automatic collect(input string name, input logic [XLEN-1:0] start, input int count,
			input int busy_pct, input logic latency, output int illegal_seen);
		int got;
		int waited;
		int idx;
		logic busy;
		logic held_valid;
		logic [XLEN-1:0] exp_pc;
		decode_data_t held;
		decode_data_t act;
		got = 0;
		waited = 0;
		held_valid = 1'b0;
		illegal_seen = 0;
		while (got < count && waited < 40 * count + 100) begin
			@(posedge i_clock);
			#1;
			waited++;
			act = read_output();
			if (held_valid) begin
				check({name, " held valid"}, 1, 32'(o_valid));
				check_item({name, " held"}, held, act);
			end
			busy = (busy_pct > 0) && (int'($urandom % 100) < busy_pct);
			i_busy = busy;
			held_valid = o_valid && busy;
			held = act;
			if (o_valid && !busy) begin
				exp_pc = start + 32'(4 * got);
				idx = word_index(exp_pc);
				check_item(name, ref_decode(exp_pc, mem[idx]), act);
				if (latency) begin
					check({name, " latency"}, 4, 32'(cycle - done_cycle[idx]));
				end
				if (act.illegal) begin
					illegal_seen++;
				end
				got++;
			end
		end
		if (got < count) begin
			errors++;
			$display("%s: timeout, only %0d of %0d instructions came out", name, got, count);
		end
	endtask

	task automatic jump_to(input string name, input logic [XLEN-1:0] target, input logic busy);
		@(posedge i_clock);
		#1;
		i_busy = busy;
		i_jump = 1'b1;
		i_jump_pc = target;
		@(posedge i_clock);
		#1;
		i_jump = 1'b0;
		check({name, " redirect request"}, 1, 32'(o_ibus_request));
		check({name, " redirect address"}, target, o_ibus_address);
		check({name, " flushed valid"}, 0, 32'(o_valid));
	endtask

	// Holds i_busy and watches the stalled output
	task automatic stall(input string name, input int cycles);
		int n;
		logic seen;
		decode_data_t first;
		seen = 1'b0;
		for (n = 0; n < cycles; n++) begin
			@(posedge i_clock);
			#1;
			if (seen) begin
				check({name, " stalled valid"}, 1, 32'(o_valid));
				check_item({name, " stalled"}, first, read_output());
			end else if (o_valid) begin
				seen = 1'b1;
				first = read_output();
			end
			i_busy = 1'b1;
		end
	endtask

	//============================================================
	// Tests
	//============================================================

	task automatic test_reset_sequential();
		int waited;
		int k;
		int illegal_seen;
		max_delay = 0;
		i_rst = 1'b1;
		for (k = 0; k < 3; k++) begin
			@(posedge i_clock);
		end
		#1;
		check("reset_seq reset valid", 0, 32'(o_valid));
		check("reset_seq reset request", 0, 32'(o_ibus_request));
		done_addr.delete();
		i_rst = 1'b0;
		waited = 0;
		while (!o_ibus_request && waited < 20) begin
			@(posedge i_clock);
			#1;
			waited++;
		end
		if (!o_ibus_request) begin
			errors++;
			$display("reset_seq: timeout, no instruction request after reset");
		end else begin
			check("reset_seq first address", RESET_VECTOR, o_ibus_address);
		end
		collect("reset_seq", RESET_VECTOR, 16, 0, 1'b0, illegal_seen);
		if (done_addr.size() < 8) begin
			errors++;
			$display("reset_seq: fewer than 8 bus reads completed");
		end else begin
			for (k = 0; k < 8; k++) begin
				check("reset_seq bus address", RESET_VECTOR + 32'(4 * k), done_addr[k]);
			end
		end
	endtask

	task automatic test_decode_formats();
		int illegal_seen;
		max_delay = 2;
		jump_to("decode_formats", 32'h100, 1'b0);
		collect("decode_formats", 32'h100, 10, 0, 1'b0, illegal_seen);
	endtask

	task automatic test_illegal();
		int illegal_seen;
		max_delay = 1;
		jump_to("illegal", 32'h200, 1'b0);
		collect("illegal", 32'h200, 6, 0, 1'b0, illegal_seen);
		check("illegal count", 4, 32'(illegal_seen));
	endtask

	task automatic test_backpressure();
		int illegal_seen;
		max_delay = 3;
		jump_to("backpressure", 32'h300, 1'b0);
		collect("backpressure", 32'h300, 40, 50, 1'b0, illegal_seen);
	endtask

	task automatic test_jump();
		int illegal_seen;
		max_delay = 2;
		jump_to("jump", 32'h380, 1'b0);
		collect("jump", 32'h380, 6, 40, 1'b0, illegal_seen);
		// Redirect while both skid buffers are full
		stall("jump", 6);
		jump_to("jump stalled", 32'h040, 1'b1);
		collect("jump stalled", 32'h040, 8, 30, 1'b0, illegal_seen);
	endtask

	task automatic test_latency();
		int illegal_seen;
		max_delay = 0;
		jump_to("latency", 32'h080, 1'b0);
		collect("latency", 32'h080, 12, 0, 1'b1, illegal_seen);
	endtask

	initial begin
		int unsigned seed_value;
		seed_value = $urandom(86);
		i_rst = 1'b1;
		i_busy = 1'b0;
		i_jump = 1'b0;
		i_jump_pc = '0;
		init_memory();
		test_reset_sequential();
		test_decode_formats();
		test_illegal();
		test_backpressure();
		test_jump();
		test_latency();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
rtl/cpu_config_pkg.sv
rtl/cpu_types_pkg.sv
rtl/cpu_stage_if.sv
rtl/cpu_fetch.sv
rtl/cpu_skid_buffer.sv
rtl/cpu_decode.sv
rtl/cpu_frontend.sv
bench/tb_cpu_frontend.sv

// File: rtl/cpu_config_pkg.sv
`default_nettype none

package cpu_config_pkg;

	//============================================================
	// Datapath widths
	//============================================================

	// Register, address and program counter width
	localparam int XLEN = 32;

	// One instruction word on the instruction bus
	localparam int ILEN = 32;

	// Sequential fetch advances by one instruction word
	localparam int PC_STEP = ILEN / 8;

	//============================================================
	// Reset state
	//============================================================

	// First fetch address after reset
	localparam logic [XLEN-1:0] RESET_VECTOR = 32'h00000000;

endpackage

`default_nettype wire

// File: rtl/cpu_decode.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_decode
	import cpu_config_pkg::*, cpu_types_pkg::*;
(
	input wire i_clock,
	input wire i_rst,

	cpu_stage_if.sink in,
	cpu_stage_if.source out
);

	fetch_data_t item;
	logic [ILEN-1:0] insn;
	logic [6:0] opcode;
	op_class_t op;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	logic [XLEN-1:0] imm;
	decode_data_t decoded;
	logic out_valid_q;
	decode_data_t out_data_q;
	logic load;

	assign item = in.data;
	assign insn = item.instruction;
	assign opcode = insn[6:0];

	//============================================================
	// Operation class
	//============================================================

	always_comb begin
		op = OP_ILLEGAL;
		// Compressed encodings are not supported
		if (insn[1:0] == 2'b11) begin
			case (opcode)
				OPC_LUI:    op = OP_LUI;
				OPC_AUIPC:  op = OP_AUIPC;
				OPC_JAL:    op = OP_JAL;
				OPC_JALR:   op = OP_JALR;
				OPC_BRANCH: op = OP_BRANCH;
				OPC_LOAD:   op = OP_LOAD;
				OPC_STORE:  op = OP_STORE;
				OPC_OP_IMM: op = OP_ALU_IMM;
				OPC_OP:     op = OP_ALU;
				OPC_SYSTEM: op = OP_SYSTEM;
				default:    op = OP_ILLEGAL;
			endcase
		end
	end

	//============================================================
	// Immediates
	//============================================================

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};
	assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

	// Pick the format by class
	always_comb begin
		case (op)
			OP_LUI, OP_AUIPC: imm = imm_u;
			OP_JAL:           imm = imm_j;
			OP_BRANCH:        imm = imm_b;
			OP_STORE:         imm = imm_s;
			OP_JALR, OP_LOAD, OP_ALU_IMM, OP_SYSTEM: imm = imm_i;
			default:          imm = '0;
		endcase
	end

	// Register fields are passed raw, execute ignores the unused ones
	always_comb begin
		decoded.pc = item.pc;
		decoded.op = op;
		decoded.funct3 = insn[14:12];
		decoded.funct7 = insn[31:25];
		decoded.rd = insn[11:7];
		decoded.rs1 = insn[19:15];
		decoded.rs2 = insn[24:20];
		decoded.imm = imm;
		decoded.illegal = (op == OP_ILLEGAL);
	end

	//============================================================
	// Output register
	//============================================================

	assign load = !out_valid_q || !out.busy;
	assign in.busy = !load;

	always_ff @(posedge i_clock) begin
		if (i_rst || in.flush) begin
			out_valid_q <= 1'b0;
		end else if (load) begin
			out_valid_q <= in.valid;
		end
	end

	always_ff @(posedge i_clock) begin
		if (load && in.valid) begin
			out_data_q <= decoded;
		end
	end

	assign out.valid = out_valid_q;
	assign out.data = out_data_q;
	assign out.flush = in.flush;

endmodule

`default_nettype wire

// File: rtl/cpu_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_fetch
	import cpu_config_pkg::*, cpu_types_pkg::*;
(
	input wire i_clock,
	input wire i_rst,

	// Redirect from execute
	input wire i_jump,
	input wire [XLEN-1:0] i_jump_pc,

	// Instruction bus
	output logic o_ibus_request,
	output logic [XLEN-1:0] o_ibus_address,
	input wire i_ibus_ready,
	input wire [ILEN-1:0] i_ibus_rdata,

	cpu_stage_if.source out
);

	logic req_q;
	logic [XLEN-1:0] pc_q;
	logic out_valid_q;
	fetch_data_t out_data_q;
	logic out_free;
	logic take;

	// Output register is empty or hands its item over this cycle
	assign out_free = !out_valid_q || !out.busy;

	// Completion lands in the output register
	assign take = req_q && i_ibus_ready && out_free && !i_jump;

	//============================================================
	// Program counter and bus request
	//============================================================

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			req_q <= 1'b0;
			pc_q <= RESET_VECTOR;
		end else if (i_jump) begin
			// Open request is abandoned
			req_q <= 1'b1;
			pc_q <= i_jump_pc;
		end else if (req_q) begin
			if (i_ibus_ready) begin
				// A completion that finds the output stalled is dropped,
				// the same pc goes out again once there is room
				req_q <= out_free;
				if (out_free) begin
					pc_q <= pc_q + XLEN'(PC_STEP);
				end
			end
		end else begin
			req_q <= out_free;
		end
	end

	assign o_ibus_request = req_q;
	assign o_ibus_address = pc_q;

	//============================================================
	// Output register
	//============================================================

	always_ff @(posedge i_clock) begin
		if (i_rst || i_jump) begin
			out_valid_q <= 1'b0;
		end else if (take) begin
			out_valid_q <= 1'b1;
		end else if (!out.busy) begin
			out_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (take) begin
			out_data_q.pc <= pc_q;
			out_data_q.instruction <= i_ibus_rdata;
		end
	end

	assign out.valid = out_valid_q;
	assign out.data = out_data_q;
	assign out.flush = i_jump;

	// Bus address may only move on completion or redirect
	addr_stable_a: assert property (@(posedge i_clock) disable iff (i_rst)
		o_ibus_request && !i_ibus_ready && !i_jump
			|=> o_ibus_request && $stable(o_ibus_address));

endmodule

`default_nettype wire

// File: rtl/cpu_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_frontend
	import cpu_config_pkg::*, cpu_types_pkg::*;
(
	input wire i_clock,
	input wire i_rst,

	// Instruction bus
	output logic o_ibus_request,
	output logic [XLEN-1:0] o_ibus_address,
	input wire i_ibus_ready,
	input wire [ILEN-1:0] i_ibus_rdata,

	// Execute side
	input wire i_busy,
	input wire i_jump,
	input wire [XLEN-1:0] i_jump_pc,
	output logic o_valid,
	output logic [XLEN-1:0] o_pc,
	output op_class_t o_op,
	output logic [2:0] o_funct3,
	output logic [6:0] o_funct7,
	output logic [4:0] o_rd,
	output logic [4:0] o_rs1,
	output logic [4:0] o_rs2,
	output logic [XLEN-1:0] o_imm,
	output logic o_illegal
);

	cpu_stage_if #(.T(fetch_data_t)) fetch_if ();
	cpu_stage_if #(.T(fetch_data_t)) fetch_skid_if ();
	cpu_stage_if #(.T(decode_data_t)) decode_raw_if ();
	cpu_stage_if #(.T(decode_data_t)) decode_if ();

	//============================================================
	// Fetch
	//============================================================

	cpu_fetch fetch (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.o_ibus_request(o_ibus_request),
		.o_ibus_address(o_ibus_address),
		.i_ibus_ready(i_ibus_ready),
		.i_ibus_rdata(i_ibus_rdata),
		.out(fetch_if.source)
	);

	cpu_skid_buffer #(.T(fetch_data_t)) fetch_skid (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.in(fetch_if.sink),
		.out(fetch_skid_if.source)
	);

	//============================================================
	// Decode
	//============================================================

	cpu_decode decode (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.in(fetch_skid_if.sink),
		.out(decode_raw_if.source)
	);

	cpu_skid_buffer #(.T(decode_data_t)) decode_skid (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.in(decode_raw_if.sink),
		.out(decode_if.source)
	);

	// Execute stall
	assign decode_if.busy = i_busy;

	assign o_valid = decode_if.valid;
	assign o_pc = decode_if.data.pc;
	assign o_op = decode_if.data.op;
	assign o_funct3 = decode_if.data.funct3;
	assign o_funct7 = decode_if.data.funct7;
	assign o_rd = decode_if.data.rd;
	assign o_rs1 = decode_if.data.rs1;
	assign o_rs2 = decode_if.data.rs2;
	assign o_imm = decode_if.data.imm;
	assign o_illegal = decode_if.data.illegal;

endmodule

`default_nettype wire

// File: rtl/cpu_skid_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_skid_buffer #(
	parameter type T = logic
) (
	input wire i_clock,
	input wire i_rst,

	cpu_stage_if.sink in,
	cpu_stage_if.source out
);

	logic main_valid;
	T main_data;
	logic skid_valid;
	T skid_data;
	logic in_xfer;
	logic main_load;

	// Registered busy, only high while both entries are full
	assign in.busy = skid_valid;
	assign in_xfer = in.valid && !skid_valid;

	// Main register takes a new item when empty or draining
	assign main_load = !main_valid || !out.busy;

	//============================================================
	// Main register
	//============================================================

	always_ff @(posedge i_clock) begin
		if (i_rst || in.flush) begin
			main_valid <= 1'b0;
		end else if (main_load) begin
			main_valid <= skid_valid || in_xfer;
		end
	end

	// Older item in the skid entry goes first
	always_ff @(posedge i_clock) begin
		if (main_load) begin
			if (skid_valid) begin
				main_data <= skid_data;
			end else if (in_xfer) begin
				main_data <= in.data;
			end
		end
	end

	//============================================================
	// Skid register
	//============================================================

	// Catches the item that arrives while the stall has not yet
	// reached the upstream stage
	always_ff @(posedge i_clock) begin
		if (i_rst || in.flush) begin
			skid_valid <= 1'b0;
		end else if (skid_valid && main_load) begin
			skid_valid <= 1'b0;
		end else if (in_xfer && !main_load) begin
			skid_valid <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (in_xfer && !main_load) begin
			skid_data <= in.data;
		end
	end

	assign out.valid = main_valid;
	assign out.data = main_data;
	assign out.flush = in.flush;

	// Item offered while both entries are full stays offered upstream
	no_accept_when_full_a: assert property (@(posedge i_clock) disable iff (i_rst)
		main_valid && skid_valid && in.valid && !in.flush
			|=> in.valid && $stable(in.data));

	// Stalled output must not change under the consumer
	hold_under_busy_a: assert property (@(posedge i_clock) disable iff (i_rst)
		out.valid && out.busy && !in.flush |=> out.valid && $stable(out.data));

endmodule

`default_nettype wire

// File: rtl/cpu_stage_if.sv
`timescale 1ns/100ps
`default_nettype none

// Valid/busy handshake between two pipeline stages
interface cpu_stage_if #(
	parameter type T = logic
) ();

	logic valid;
	T data;
	logic busy;

	// Redirect from fetch, drops everything held downstream
	logic flush;

	modport source (
		output valid,
		output data,
		output flush,
		input busy
	);

	modport sink (
		input valid,
		input data,
		input flush,
		output busy
	);

endinterface

`default_nettype wire

// File: rtl/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

	import cpu_config_pkg::*;

	//============================================================
	// RV32I major opcodes
	//============================================================

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// Operation class handed to execute
	typedef enum logic [3:0] {
		OP_LUI,
		OP_AUIPC,
		OP_JAL,
		OP_JALR,
		OP_BRANCH,
		OP_LOAD,
		OP_STORE,
		OP_ALU_IMM,
		OP_ALU,
		OP_SYSTEM,
		OP_ILLEGAL
	} op_class_t;

	//============================================================
	// Stage payloads
	//============================================================

	// Fetched word together with its address
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [ILEN-1:0] instruction;
	} fetch_data_t;

	// Decoded item, immediate already sign extended
	typedef struct packed {
		logic [XLEN-1:0] pc;
		op_class_t op;
		logic [2:0] funct3;
		logic [6:0] funct7;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [XLEN-1:0] imm;
		logic illegal;
	} decode_data_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/100ps \
	--top-module tb_cpu_frontend \
	-Mdir obj_dir \
	-f compile.f

./obj_dir/Vtb_cpu_frontend | tee sim.log

if grep -qx "all tests passed" sim.log; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed, see sim.log"
exit 1
